// ==== sim.f ====
+incdir+common
common/rf_pkg.sv
common/issue_pkg.sv
regfile/regfile.sv
src/operand_fetch.sv
src/rf_subsystem_top.sv
verification/tb_rf_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator; the exit status reports the result.
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module tb_rf_subsystem -Mdir obj_dir &&
./obj_dir/Vtb_rf_subsystem || exit 1

// ==== verification/tb_rf_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_consts.svh"

module tb_rf_subsystem
    import rf_pkg::*;
    import issue_pkg::*;
();

    // ********************
    // Run limits
    // ********************

    localparam int RANDOM_CYCLES = 2000;
    localparam int MAX_CYCLES    = 2200;  // Reset, sweep, random, directed, margin.

    logic        clk;
    logic        rst_n;
    issue_pair_t issue;
    rf_wr_t      wb0;
    rf_wr_t      wb1;
    fetch_out_t  fetched;

    integer      seed;
    int          cycle_count;
    reg_data_t   model_regs [`RF_NUM_REGS];
    fetch_out_t  exp_q;  // Due after the next edge.

    rf_subsystem_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issue),
        .wb0     (wb0),
        .wb1     (wb1),
        .fetched (fetched)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    // ********************
    // Compare tasks
    // ********************

    task automatic check_operand(input string name, input operand_t exp, input operand_t act);
        if (act !== exp) begin
            $display("error: time %0t %s expected %h actual %h", $time, name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "operand mismatch");
        end
    endtask

    task automatic check_hazard(input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: time %0t fetched.pair_hazard expected %b actual %b",
                     $time, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "hazard mismatch");
        end
    endtask

    // ********************
    // Reference model
    // ********************

    function automatic reg_data_t model_read(input reg_addr_t a, input rf_wr_t w0,
                                             input rf_wr_t w1);
        if (a == '0) begin
            return '0;
        end
        if (w1.en && (w1.addr == a)) begin
            return w1.data;  // Younger write first.
        end
        if (w0.en && (w0.addr == a)) begin
            return w0.data;
        end
        return model_regs[a];
    endfunction

    function automatic logic model_hazard(input issue_pair_t p);
        return p.slot[0].valid && p.slot[1].valid && p.slot[0].dst_wr &&
               (p.slot[0].dst != '0) &&
               ((p.slot[1].src_a == p.slot[0].dst) || (p.slot[1].src_b == p.slot[0].dst));
    endfunction

    // Checks the pair from the last cycle, then drives and predicts this one.
    task automatic run_cycle(input issue_pair_t p, input rf_wr_t w0, input rf_wr_t w1);
        check_operand("fetched.op[0]", exp_q.op[0], fetched.op[0]);
        check_operand("fetched.op[1]", exp_q.op[1], fetched.op[1]);
        check_hazard(exp_q.pair_hazard, fetched.pair_hazard);
        issue = p;
        wb0   = w0;
        wb1   = w1;
        for (int s = 0; s < 2; s++) begin
            exp_q.op[s].valid  = p.slot[s].valid;
            exp_q.op[s].dst_wr = p.slot[s].dst_wr;
            exp_q.op[s].dst    = p.slot[s].dst;
            exp_q.op[s].op_a   = model_read(p.slot[s].src_a, w0, w1);
            exp_q.op[s].op_b   = model_read(p.slot[s].src_b, w0, w1);
        end
        exp_q.pair_hazard = model_hazard(p);
        if (w0.en && (w0.addr != '0)) begin
            model_regs[w0.addr] = w0.data;
        end
        if (w1.en && (w1.addr != '0)) begin
            model_regs[w1.addr] = w1.data;  // Overrides wb0 on a tie.
        end
        @(posedge clk);
        #1;
    endtask

    // ********************
    // Stimulus
    // ********************

    function automatic reg_addr_t rand_addr();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] < 4'd12) begin
            return {2'b00, r[6:4]};  // Low registers.
        end
        return r[8:4];
    endfunction

    function automatic issue_slot_t rand_slot();
        issue_slot_t s;
        logic [31:0] r;
        r        = $random(seed);
        s.valid  = (r[1:0] != 2'b00);
        s.dst_wr = r[2];
        s.dst    = rand_addr();
        s.src_a  = rand_addr();
        s.src_b  = rand_addr();
        return s;
    endfunction

    function automatic rf_wr_t rand_wr();
        rf_wr_t w;
        logic [31:0] r;
        r      = $random(seed);
        w.en   = r[0] | r[1];
        w.addr = rand_addr();
        w.data = $random(seed);
        return w;
    endfunction

    function automatic issue_slot_t make_slot(input logic valid, input logic dst_wr,
                                              input reg_addr_t dst, input reg_addr_t a,
                                              input reg_addr_t b);
        issue_slot_t s;
        s.valid  = valid;
        s.dst_wr = dst_wr;
        s.dst    = dst;
        s.src_a  = a;
        s.src_b  = b;
        return s;
    endfunction

    function automatic rf_wr_t make_wr(input logic en, input reg_addr_t addr,
                                       input reg_data_t data);
        rf_wr_t w;
        w.en   = en;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    initial begin
        issue_pair_t p;
        rf_wr_t      w0;
        rf_wr_t      w1;
        seed        = 32'hec03;
        cycle_count = 0;
        rst_n       = 1'b0;
        // Valid pair with a hazard held through reset.
        p.slot[0]   = make_slot(1'b1, 1'b1, 5'd1, 5'd0, 5'd0);
        p.slot[1]   = make_slot(1'b1, 1'b0, 5'd0, 5'd1, 5'd0);
        issue       = p;
        wb0         = '0;
        wb1         = '0;
        exp_q       = '0;  // Valid bits and hazard cleared by reset.
        for (int s = 0; s < 2; s++) begin
            exp_q.op[s].dst_wr = p.slot[s].dst_wr;
            exp_q.op[s].dst    = p.slot[s].dst;
        end
        for (int i = 0; i < `RF_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Every register read once before any write.
        for (int k = 0; k < 8; k++) begin
            p.slot[0] = make_slot(1'b1, 1'b0, 5'd0, reg_addr_t'(4*k), reg_addr_t'(4*k+1));
            p.slot[1] = make_slot(1'b1, 1'b0, 5'd0, reg_addr_t'(4*k+2), reg_addr_t'(4*k+3));
            run_cycle(p, '0, '0);
        end

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            p.slot[0] = rand_slot();
            p.slot[1] = rand_slot();
            w0        = rand_wr();
            w1        = rand_wr();
            run_cycle(p, w0, w1);
        end

        // Both ports on r5 while all four ports read it.
        p.slot[0] = make_slot(1'b1, 1'b0, 5'd0, 5'd5, 5'd5);
        p.slot[1] = make_slot(1'b1, 1'b0, 5'd0, 5'd5, 5'd5);
        run_cycle(p, make_wr(1'b1, 5'd5, 32'h1111_0005), make_wr(1'b1, 5'd5, 32'h2222_0005));
        run_cycle(p, '0, '0);  // Stored wb1 value.
        p.slot[0] = make_slot(1'b1, 1'b0, 5'd0, 5'd0, 5'd0);
        p.slot[1] = make_slot(1'b1, 1'b0, 5'd0, 5'd0, 5'd0);
        run_cycle(p, make_wr(1'b1, 5'd0, 32'hdead_0000), make_wr(1'b1, 5'd0, 32'hbeef_0000));
        // wb0 bypass into a dependent pair.
        p.slot[0] = make_slot(1'b1, 1'b1, 5'd9, 5'd9, 5'd3);
        p.slot[1] = make_slot(1'b1, 1'b0, 5'd0, 5'd9, 5'd0);
        run_cycle(p, make_wr(1'b1, 5'd9, 32'h3333_0009), '0);
        p.slot[1].valid = 1'b0;  // Empty slot, no hazard.
        run_cycle(p, '0, '0);
        run_cycle('0, '0, '0);  // Drain.

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/rf_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_subsystem_top
    import rf_pkg::*;
    import issue_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    input  wire issue_pair_t issue,   // Pair entering operand read.

    input  wire rf_wr_t      wb0,     // Older write-back.
    input  wire rf_wr_t      wb1,     // Younger write-back, wins ties.

    output wire fetch_out_t  fetched  // Operands for execute.
);

    // ********************
    // Read path
    // ********************

    wire reg_addr_t rd_addr [4];
    wire reg_data_t rd_data [4];

    operand_fetch u_operand_fetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issue),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .fetched (fetched)
    );

    // ********************
    // Register file
    // ********************

    // Write-back goes straight in; no stall or flush on this side.
    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr0     (wb0),
        .wr1     (wb1)
    );

endmodule

`default_nettype wire

// ==== src/operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch
    import rf_pkg::*;
    import issue_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    input  wire issue_pair_t issue,

    output reg_addr_t        rd_addr [4],
    input  wire reg_data_t   rd_data [4],

    output fetch_out_t       fetched
);

    // ********************
    // Read port mapping
    // ********************

    // Port order is s0.a, s0.b, s1.a, s1.b.
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            rd_addr[2*s]   = issue.slot[s].src_a;
            rd_addr[2*s+1] = issue.slot[s].src_b;
        end
    end

    // ********************
    // In-pair dependency
    // ********************

    logic s0_writes;
    logic s1_uses_s0;
    logic hazard;

    assign s0_writes  = issue.slot[0].dst_wr && (issue.slot[0].dst != '0);
    assign s1_uses_s0 = (issue.slot[1].src_a == issue.slot[0].dst) ||
                        (issue.slot[1].src_b == issue.slot[0].dst);

    // An empty slot never raises the flag.
    assign hazard = issue.slot[0].valid && issue.slot[1].valid &&
                    s0_writes && s1_uses_s0;

    // ********************
    // Output registers
    // ********************

    logic [1:0] valid_q;
    logic       hazard_q;
    logic [1:0] dst_wr_q;
    reg_addr_t  dst_q  [2];
    reg_data_t  op_a_q [2];
    reg_data_t  op_b_q [2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            hazard_q <= 1'b0;
        end else begin
            valid_q  <= {issue.slot[1].valid, issue.slot[0].valid};
            hazard_q <= hazard;
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            dst_wr_q[s] <= issue.slot[s].dst_wr;
            dst_q[s]    <= issue.slot[s].dst;
            op_a_q[s]   <= rd_data[2*s];    // Bypassed value.
            op_b_q[s]   <= rd_data[2*s+1];
        end
    end

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            fetched.op[s].valid  = valid_q[s];
            fetched.op[s].dst_wr = dst_wr_q[s];
            fetched.op[s].dst    = dst_q[s];
            fetched.op[s].op_a   = op_a_q[s];
            fetched.op[s].op_b   = op_b_q[s];
        end
        fetched.pair_hazard = hazard_q;
    end

endmodule

`default_nettype wire

// ==== regfile/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_consts.svh"

module regfile
    import rf_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,

    input  wire reg_addr_t rd_addr [4],
    output reg_data_t      rd_data [4],

    input  wire rf_wr_t    wr0,
    input  wire rf_wr_t    wr1
);

    // ********************
    // Storage
    // ********************

    reg_data_t regs [1:`RF_NUM_REGS-1];  // No storage behind register zero.

    logic wr0_act;
    logic wr1_act;

    // Writes to register zero are dropped here.
    assign wr0_act = wr0.en && (wr0.addr != '0);
    assign wr1_act = wr1.en && (wr1.addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RF_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0_act) begin
                regs[wr0.addr] <= wr0.data;
            end
            if (wr1_act) begin
                regs[wr1.addr] <= wr1.data;  // Port 1 wins a tie.
            end
        end
    end

    // ********************
    // Read ports
    // ********************

    // Each port looks at both write ports first so that a value being
    // written this cycle is seen without waiting for the edge.
    for (genvar p = 0; p < 4; p++) begin : g_rd
        logic      is_zero;
        logic      hit0;
        logic      hit1;
        reg_data_t stored;

        assign is_zero = (rd_addr[p] == '0);
        assign hit0    = wr0.en && (wr0.addr == rd_addr[p]);
        assign hit1    = wr1.en && (wr1.addr == rd_addr[p]);

        always_comb begin
            if (is_zero) begin
                stored = '0;
            end else begin
                stored = regs[rd_addr[p]];
            end
        end

        always_comb begin
            if (is_zero) begin
                rd_data[p] = '0;  // Hardwired zero.
            end else if (hit1) begin
                rd_data[p] = wr1.data;
            end else if (hit0) begin
                rd_data[p] = wr0.data;
            end else begin
                rd_data[p] = stored;
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    import rf_pkg::*;

    // ********************
    // Issue side
    // ********************

    typedef struct packed {
        logic      valid;   // Slot holds an instruction.
        logic      dst_wr;  // Instruction writes dst.
        reg_addr_t dst;
        reg_addr_t src_a;
        reg_addr_t src_b;
    } issue_slot_t;

    // Slot 0 is the older instruction.
    typedef struct packed {
        issue_slot_t [1:0] slot;
    } issue_pair_t;

    // ********************
    // Execute side
    // ********************

    typedef struct packed {
        logic      valid;
        logic      dst_wr;
        reg_addr_t dst;
        reg_data_t op_a;  // Value of src_a.
        reg_data_t op_b;  // Value of src_b.
    } operand_t;

    typedef struct packed {
        operand_t [1:0] op;
        logic           pair_hazard;  // Slot 1 depends on slot 0.
    } fetch_out_t;

endpackage

`default_nettype wire

// ==== common/rf_pkg.sv ====
`default_nettype none

`include "rf_consts.svh"

package rf_pkg;

    // ********************
    // Register file types
    // ********************

    typedef logic [`RF_ADDR_W-1:0] reg_addr_t;  // Register index.

    typedef logic [`RF_DATA_W-1:0] reg_data_t;  // Register value.

    // One write-back port.
    typedef struct packed {
        logic      en;    // Write enable.
        reg_addr_t addr;  // Target register.
        reg_data_t data;  // Value to store.
    } rf_wr_t;

endpackage

`default_nettype wire

// ==== common/rf_consts.svh ====
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// ********************
// Register file sizing
// ********************

`define RF_NUM_REGS 32  // Architectural registers.
`define RF_ADDR_W   5   // Index width.
`define RF_DATA_W   32  // Word width.

`endif
